// File: tests/edp_patterns.txt
# kind ada adb alu cin arSel arLd arxLd brLd brxLd mq fmAdr wL wR cacheData diagSel expData expCarry expOwner
# kind S step, A check ad/adCarry, L time base load, D diag read, R both peers read, X reset
# ALU functions, AR = F00000001 and BR = 123456789
S 0 0 0 0 0 1 0 0 0 0 0 0 0 123456789 0 000000000 0 0
S 0 0 0 0 0 1 0 1 0 0 0 0 0 F00000001 0 000000000 0 0
A 0 1 0 0 0 0 0 0 0 0 0 0 0 000000000 0 02345678A 1 0
A 0 1 0 1 0 0 0 0 0 0 0 0 0 000000000 0 02345678B 1 0
A 0 1 1 0 0 0 0 0 0 0 0 0 0 000000000 0 DDCBA9878 1 0
A 3 1 1 0 0 0 0 0 0 0 0 0 0 000000000 0 EDCBA9877 0 0
A 0 1 2 0 0 0 0 0 0 0 0 0 0 000000000 0 100000001 0 0
A 0 1 3 0 0 0 0 0 0 0 0 0 0 000000000 0 F23456789 0 0
A 0 1 4 0 0 0 0 0 0 0 0 0 0 000000000 0 E23456788 0 0
A 0 1 5 0 0 0 0 0 0 0 0 0 0 000000000 0 F00000001 0 0
# Shifted B operands, ARX and BRX = F00000001
S 0 0 5 0 0 0 1 0 0 0 0 0 0 000000000 0 000000000 0 0
S 0 0 0 0 0 0 0 0 1 0 0 0 0 000000000 0 000000000 0 0
A 3 2 3 0 0 0 0 0 0 0 0 0 0 000000000 0 2468ACF13 0 0
A 3 3 3 0 0 0 0 0 0 0 0 0 0 000000000 0 C00000007 0 0
# FM halfword writes at addresses 3 and 4
S 0 0 0 0 0 1 0 0 0 0 0 0 0 000000000 0 000000000 0 0
S 0 0 0 0 0 1 0 0 0 0 3 1 1 FFFFFFFFF 0 000000000 0 0
S 0 0 0 0 0 1 0 0 0 0 4 1 1 123456789 0 000000000 0 0
S 0 0 0 0 0 0 0 0 0 0 3 1 0 000000000 0 000000000 0 0
S 0 0 0 0 0 0 0 0 0 0 4 0 1 000000000 0 000000000 0 0
A 3 0 3 0 0 0 0 0 0 0 3 0 0 000000000 0 123440000 0 0
A 3 0 3 0 0 0 0 0 0 0 4 0 0 000000000 0 FFFFD6789 0 0
# MQ load, shift left with carry in, then two sign keeping right shifts
S 3 1 1 0 0 0 0 0 0 1 0 0 0 000000000 0 000000000 0 0
D 0 0 0 0 0 0 0 0 0 0 0 0 0 000000000 2 EDCBA9877 0 1
A 0 0 0 0 0 0 0 0 0 2 4 0 0 000000000 0 12342CF12 1 0
D 0 0 0 0 0 0 0 0 0 0 0 0 0 000000000 2 DB97530EF 0 1
S 0 0 0 0 0 0 0 0 0 3 0 0 0 000000000 0 000000000 0 0
D 0 0 0 0 0 0 0 0 0 0 0 0 0 000000000 2 EDCBA9877 0 1
S 0 0 0 0 0 0 0 0 0 3 0 0 0 000000000 0 000000000 0 0
D 0 0 0 0 0 0 0 0 0 0 0 0 0 000000000 2 F6E5D4C3B 0 1
# Arbitration after reset, data path first
X 0 0 0 0 0 0 0 0 0 0 0 0 0 000000000 0 000000000 0 0
S 0 0 0 0 0 1 0 0 0 0 0 0 0 000001000 0 000000000 0 0
L 0 0 5 0 0 0 0 0 0 0 0 0 0 000000000 0 000001000 0 0
S 0 0 0 0 0 0 0 0 0 0 0 0 0 000000000 0 000000000 0 0
S 0 0 0 0 0 0 0 0 0 0 0 0 0 000000000 0 000000000 0 0
R 0 0 0 0 0 0 0 0 0 0 0 0 0 000000000 0 000001000 0 1
# Round robin, the peer that did not own the bus last goes first
R 0 0 0 0 0 0 0 0 0 0 0 0 0 000000000 0 000001000 0 1
D 0 0 0 0 0 0 0 0 0 0 0 0 0 000000000 0 000001000 0 1
S 0 0 0 0 0 1 0 0 0 0 0 0 0 7FFFFFF00 0 000000000 0 0
L 0 0 5 0 0 0 0 0 0 0 0 0 0 000000000 0 7FFFFFF00 0 0
S 0 0 0 0 0 0 0 0 0 0 0 0 0 000000000 0 000000000 0 0
S 0 0 0 0 0 0 0 0 0 0 0 0 0 000000000 0 000000000 0 0
R 0 0 0 0 0 0 0 0 0 0 0 0 0 000000000 0 7FFFFFF00 0 2

// File: files.f
+incdir+src
src/edpPkg.sv
src/edpAlu.sv
src/fastMem.sv
src/edpCore.sv
src/timeBase.sv
src/ebusArbiter.sv
src/ebox.sv
tests/tbEbox.sv

// File: run.sh
#!/bin/sh
# Build and run the EBOX testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tbEbox &&
./obj_dir/VtbEbox | tee /dev/stderr | grep -q "All tests passed" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: tests/tbEbox.sv
`timescale 1ns/10ps
`include "edp_params.svh"

module tbEbox;
  import edpPkg::*;

  localparam int clkPeriod = 40;
  // Cycles allowed for an EBUS valid pulse to show up
  localparam int validTimeout = 50;
  localparam string patternPath = "tests/edp_patterns.txt";

  logic      CLK;
  logic      arstN;
  tMicroWord uop;
  tWord      cacheData;
  logic      diagRead;
  tDiagSel   diagSel;
  logic      tbRead;
  logic      tbLoad;
  tWord      ad;
  logic      adCarry;
  tWord      ebusData;
  logic      ebusValid;
  tOwner     ebusOwner;

  // Value last loaded into the time base
  tWord loadValue;
  int   lineNo = 0;
  int   checksRun = 0;

  ebox dut_i (
    .CLK       (CLK),
    .arstN     (arstN),
    .uop       (uop),
    .cacheData (cacheData),
    .diagRead  (diagRead),
    .diagSel   (diagSel),
    .tbRead    (tbRead),
    .tbLoad    (tbLoad),
    .ad        (ad),
    .adCarry   (adCarry),
    .ebusData  (ebusData),
    .ebusValid (ebusValid),
    .ebusOwner (ebusOwner)
  );

  initial begin
    CLK = 1'b0;
    forever begin
      #(clkPeriod / 2) CLK = ~CLK;
    end
  end

  task automatic abortRun();
    $display("Some tests failed");
    $fatal(1, "Simulation stopped at pattern line %0d", lineNo);
  endtask

  task automatic checkWord(input string name, input tWord got, input tWord exp);
    checksRun++;
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h (line %0d)", name, got, exp, lineNo);
      abortRun();
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    checksRun++;
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h (line %0d)", name, got, exp, lineNo);
      abortRun();
    end
  endtask

  task automatic checkOwner(input string name, input tOwner got, input tOwner exp);
    checksRun++;
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h (line %0d)", name, got, exp, lineNo);
      abortRun();
    end
  endtask

  // Lower bound only since the count keeps running while the read waits
  task automatic checkAtLeast(input string name, input tWord got, input tWord low);
    checksRun++;
    if ($isunknown(got) || got < low) begin
      $display("[ERROR] %s: got 0x%h, expected at least 0x%h (line %0d)",
               name, got, low, lineNo);
      abortRun();
    end
  endtask

  task automatic resetDut();
    uop      = '0;
    diagRead = 1'b0;
    tbRead   = 1'b0;
    tbLoad   = 1'b0;
    arstN    = 1'b0;
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    arstN = 1'b1;
  endtask

  // Returns on the falling edge where ebusValid is seen high
  task automatic waitValid(input string what);
    int cycles;
    cycles = 0;
    while (ebusValid !== 1'b1) begin
      if (cycles == validTimeout) begin
        $display("Timeout: no EBUS valid pulse within %0d cycles for the %s (line %0d)",
                 validTimeout, what, lineNo);
        abortRun();
      end
      @(negedge CLK);
      cycles++;
    end
  endtask

  // A bus cycle is a one cycle valid pulse
  task automatic finishBusCycle();
    @(negedge CLK);
    checkBit("ebusValid", ebusValid, 1'b0);
  endtask

  task automatic checkBusCycle(input tOwner owner, input tWord edpData);
    checkOwner("ebusOwner", ebusOwner, owner);
    if (owner == ownEdp) begin
      checkWord("ebusData", ebusData, edpData);
    end else begin
      // Read strobe comes two cycles after the load at the earliest
      checkAtLeast("ebusData", ebusData, loadValue + tWord'(2));
    end
  endtask

  task automatic diagnosticRead(input tOwner owner, input tWord expData);
    diagRead = 1'b1;
    @(negedge CLK);
    diagRead = 1'b0;
    uop      = '0;
    waitValid("diagnostic read");
    checkBusCycle(owner, expData);
    finishBusCycle();
  endtask

  // Both peers request in the same cycle
  task automatic arbitrate(input tOwner first, input tWord edpData);
    tOwner second;
    second   = (first == ownEdp) ? ownTime : ownEdp;
    diagRead = 1'b1;
    tbRead   = 1'b1;
    @(negedge CLK);
    diagRead = 1'b0;
    tbRead   = 1'b0;
    uop      = '0;
    waitValid("first arbitrated bus cycle");
    checkBusCycle(first, edpData);
    finishBusCycle();
    waitValid("second arbitrated bus cycle");
    checkBusCycle(second, edpData);
    finishBusCycle();
  endtask

  initial begin
    int               fd;
    int               nItems;
    string            line;
    logic [7:0]       kind;
    int               fld [16];
    logic [`WORD_W-1:0] cacheWord;
    logic [`WORD_W-1:0] expWord;
    uop       = '0;
    cacheData = '0;
    diagRead  = 1'b0;
    diagSel   = diagAR;
    tbRead    = 1'b0;
    tbLoad    = 1'b0;
    arstN     = 1'b0;
    loadValue = '0;
    fd = $fopen(patternPath, "r");
    if (fd == 0) begin
      $display("Cannot open the pattern file %s", patternPath);
      abortRun();
    end
    resetDut();
    while ($fgets(line, fd) != 0) begin
      lineNo++;
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      nItems = $sscanf(line,
        "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
        kind, fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
        fld[8], fld[9], fld[10], fld[11], fld[12], cacheWord, fld[13], expWord,
        fld[14], fld[15]);
      if (nItems != 19) begin
        $display("Pattern line %0d has %0d fields instead of 19", lineNo, nItems);
        abortRun();
      end
      // Drive on the falling edge
      uop.ada      = tAdaSel'(fld[0][1:0]);
      uop.adb      = tAdbSel'(fld[1][1:0]);
      uop.aluFunc  = tAluFunc'(fld[2][2:0]);
      uop.carryIn  = fld[3][0];
      uop.arSel    = tArSel'(fld[4][1:0]);
      uop.arLoad   = fld[5][0];
      uop.arxLoad  = fld[6][0];
      uop.brLoad   = fld[7][0];
      uop.brxLoad  = fld[8][0];
      uop.mqFunc   = tMqFunc'(fld[9][1:0]);
      uop.fmAdr    = tFmAdr'(fld[10]);
      uop.fmWriteL = fld[11][0];
      uop.fmWriteR = fld[12][0];
      cacheData    = cacheWord;
      diagSel      = tDiagSel'(fld[13][`DIAG_W-1:0]);
      case (kind)
        "S": begin
          @(negedge CLK);
        end
        "A": begin
          // Combinational AD path has settled by mid low phase
          #(clkPeriod / 4);
          checkWord("ad", ad, expWord);
          checkBit("adCarry", adCarry, fld[14][0]);
          @(negedge CLK);
        end
        "L": begin
          tbLoad = 1'b1;
          #(clkPeriod / 4);
          checkWord("ad", ad, expWord);
          loadValue = expWord;
          @(negedge CLK);
          tbLoad = 1'b0;
        end
        "D": begin
          diagnosticRead(tOwner'(fld[15][1:0]), expWord);
        end
        "R": begin
          arbitrate(tOwner'(fld[15][1:0]), expWord);
        end
        "X": begin
          resetDut();
        end
        default: begin
          $display("Unknown operation kind '%s' on pattern line %0d", kind, lineNo);
          abortRun();
        end
      endcase
    end
    $fclose(fd);
    if (checksRun > 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("No checks ran, the pattern file holds no operations");
      abortRun();
    end
  end

endmodule

// File: src/ebox.sv
`timescale 1ns/10ps

module ebox (
  input  logic              CLK,
  input  logic              arstN,
  input  edpPkg::tMicroWord uop,
  input  edpPkg::tWord      cacheData,
  input  logic              diagRead,
  input  edpPkg::tDiagSel   diagSel,
  input  logic              tbRead,
  input  logic              tbLoad,
  output edpPkg::tWord      ad,
  output logic              adCarry,
  output edpPkg::tWord      ebusData,
  output logic              ebusValid,
  output edpPkg::tOwner     ebusOwner
);
  import edpPkg::*;

  tWord   adA;
  tWord   adB;
  tWord   ar;
  tWord   fm;
  tBusReq edpReq;
  tBusReq tbReq;
  logic   edpGrant;
  logic   tbGrant;

  // EBUS loops back so AR can take diagnostic data
  edpCore core_i (
    .CLK       (CLK),
    .arstN     (arstN),
    .uop       (uop),
    .cacheData (cacheData),
    .ebusIn    (ebusData),
    .fm        (fm),
    .ad        (ad),
    .adCarry   (adCarry),
    .diagRead  (diagRead),
    .diagSel   (diagSel),
    .grant     (edpGrant),
    .adA       (adA),
    .adB       (adB),
    .ar        (ar),
    .busReq    (edpReq)
  );

  // Overflow has no user in this cut-down data path
  edpAlu alu_i (
    .a        (adA),
    .b        (adB),
    .func     (uop.aluFunc),
    .carryIn  (uop.carryIn),
    .ad       (ad),
    .carry    (adCarry),
    .overflow ()
  );

  fastMem fm_i (
    .CLK    (CLK),
    .adr    (uop.fmAdr),
    .din    (ar),
    .writeL (uop.fmWriteL),
    .writeR (uop.fmWriteR),
    .dout   (fm)
  );

  // Time base loads straight from AD
  timeBase timeBase_i (
    .CLK       (CLK),
    .arstN     (arstN),
    .load      (tbLoad),
    .loadValue (ad),
    .read      (tbRead),
    .grant     (tbGrant),
    .busReq    (tbReq)
  );

  ebusArbiter arbiter_i (
    .CLK       (CLK),
    .arstN     (arstN),
    .edpReq    (edpReq),
    .tbReq     (tbReq),
    .edpGrant  (edpGrant),
    .tbGrant   (tbGrant),
    .ebusData  (ebusData),
    .ebusValid (ebusValid),
    .ebusOwner (ebusOwner)
  );

endmodule

// File: src/ebusArbiter.sv
`timescale 1ns/10ps

module ebusArbiter (
  input  logic           CLK,
  input  logic           arstN,
  input  edpPkg::tBusReq edpReq,
  input  edpPkg::tBusReq tbReq,
  output logic           edpGrant,
  output logic           tbGrant,
  output edpPkg::tWord   ebusData,
  output logic           ebusValid,
  output edpPkg::tOwner  ebusOwner
);
  import edpPkg::*;

  // Set when the data path owned the bus last
  logic lastEdp;
  logic pickEdp;
  logic pickTb;

  // No new grant in a bus cycle, the owner drops req at its end
  always_comb begin
    pickEdp = 1'b0;
    pickTb  = 1'b0;
    if (!ebusValid) begin
      if (edpReq.req && tbReq.req) begin
        pickEdp = !lastEdp;
        pickTb  = lastEdp;
      end else begin
        pickEdp = edpReq.req;
        pickTb  = tbReq.req;
      end
    end
  end

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      edpGrant <= 1'b0;
      tbGrant  <= 1'b0;
      lastEdp  <= 1'b0;
    end else begin
      edpGrant <= pickEdp;
      tbGrant  <= pickTb;
      if (pickEdp || pickTb) begin
        lastEdp <= pickEdp;
      end
    end
  end

  assign ebusValid = edpGrant | tbGrant;

  always_comb begin
    if (edpGrant) begin
      ebusData  = edpReq.data;
      ebusOwner = ownEdp;
    end else if (tbGrant) begin
      ebusData  = tbReq.data;
      ebusOwner = ownTime;
    end else begin
      ebusData  = '0;
      ebusOwner = ownNone;
    end
  end

  oneOwner: assert property (
    @(posedge CLK) disable iff (!arstN) !(edpGrant && tbGrant)
  ) else $error("ebusArbiter: both peers granted");

endmodule

// File: src/timeBase.sv
`timescale 1ns/10ps

module timeBase (
  input  logic           CLK,
  input  logic           arstN,
  input  logic           load,
  input  edpPkg::tWord   loadValue,
  input  logic           read,
  input  logic           grant,
  output edpPkg::tBusReq busReq
);
  import edpPkg::*;

  tWord count;

  // Free running, load wins over the increment
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      count <= '0;
    end else if (load) begin
      count <= loadValue;
    end else begin
      count <= count + 1'b1;
    end
  end

  // Snapshot of the count, held until granted
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      busReq <= '0;
    end else if (read && (!busReq.req || grant)) begin
      busReq.req  <= 1'b1;
      busReq.data <= count;
    end else if (grant) begin
      busReq.req <= 1'b0;
    end
  end

endmodule

// File: src/edpCore.sv
`timescale 1ns/10ps

module edpCore (
  input  logic              CLK,
  input  logic              arstN,
  input  edpPkg::tMicroWord uop,
  input  edpPkg::tWord      cacheData,
  input  edpPkg::tWord      ebusIn,
  input  edpPkg::tWord      fm,
  input  edpPkg::tWord      ad,
  input  logic              adCarry,
  input  logic              diagRead,
  input  edpPkg::tDiagSel   diagSel,
  input  logic              grant,
  output edpPkg::tWord      adA,
  output edpPkg::tWord      adB,
  output edpPkg::tWord      ar,
  output edpPkg::tBusReq    busReq
);
  import edpPkg::*;

  tWord arx;
  tWord br;
  tWord brx;
  tWord mq;

  tWord arIn;
  tWord mqNext;
  tWord diagData;

  // AR source mux
  always_comb begin
    case (uop.arSel)
      arCache: arIn = cacheData;
      arAd:    arIn = ad;
      arEbus:  arIn = ebusIn;
      default: arIn = mq;
    endcase
  end

  // MQ behaves like a universal shift register
  always_comb begin
    case (uop.mqFunc)
      mqLoad:  mqNext = ad;
      mqShl:   mqNext = {mq[1:35], adCarry};
      // Right shift keeps the sign
      mqShr:   mqNext = {mq[0], mq[0:34]};
      default: mqNext = mq;
    endcase
  end

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      ar  <= '0;
      arx <= '0;
      br  <= '0;
      brx <= '0;
      mq  <= '0;
    end else begin
      if (uop.arLoad) begin
        ar <= arIn;
      end
      if (uop.arxLoad) begin
        arx <= ad;
      end
      if (uop.brLoad) begin
        br <= ar;
      end
      if (uop.brxLoad) begin
        brx <= arx;
      end
      mq <= mqNext;
    end
  end

  // ADA mux
  always_comb begin
    case (uop.ada)
      adaAR:   adA = ar;
      adaARX:  adA = arx;
      adaMQ:   adA = mq;
      default: adA = '0;
    endcase
  end

  // ADB mux, the shifted forms borrow low bits from the X register
  always_comb begin
    case (uop.adb)
      adbFM:   adB = fm;
      adbBR:   adB = br;
      adbBRx2: adB = {br[1:35], brx[0]};
      default: adB = {ar[2:35], arx[0:1]};
    endcase
  end

  // Diagnostic register select
  always_comb begin
    case (diagSel)
      diagAR:  diagData = ar;
      diagBR:  diagData = br;
      diagMQ:  diagData = mq;
      diagFM:  diagData = fm;
      diagBRX: diagData = brx;
      diagARX: diagData = arx;
      diagAD:  diagData = ad;
      default: diagData = '0;
    endcase
  end

  // Hold the request until the arbiter grants it, a read during
  // the grant cycle chains straight into the next request
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      busReq <= '0;
    end else if (diagRead && (!busReq.req || grant)) begin
      busReq.req  <= 1'b1;
      busReq.data <= diagData;
    end else if (grant) begin
      busReq.req <= 1'b0;
    end
  end

  reqHeldUntilGrant: assert property (
    @(posedge CLK) disable iff (!arstN)
    busReq.req && !grant |=> busReq.req && $stable(busReq.data)
  ) else $error("edpCore: EBUS request changed before grant");

endmodule

// File: src/fastMem.sv
`timescale 1ns/10ps
`include "edp_params.svh"

module fastMem (
  input  logic          CLK,
  input  edpPkg::tFmAdr adr,
  input  edpPkg::tWord  din,
  input  logic          writeL,
  input  logic          writeR,
  output edpPkg::tWord  dout
);
  import edpPkg::*;

  // Left and right halves kept apart so each half writes on its own
  tHalf memL [`FM_DEPTH];
  tHalf memR [`FM_DEPTH];

  tHalf dinL;
  tHalf dinR;

  assign dinL = din[0:`HALF_W-1];
  assign dinR = din[`HALF_W:`WORD_W-1];

  // Left half, bits 0..17
  always_ff @(posedge CLK) begin
    if (writeL) begin
      memL[adr] <= dinL;
    end
  end

  // Right half, bits 18..35
  always_ff @(posedge CLK) begin
    if (writeR) begin
      memR[adr] <= dinR;
    end
  end

  // Read is combinational, new data shows after the write edge
  assign dout = {memL[adr], memR[adr]};

endmodule

// File: src/edpAlu.sv
`timescale 1ns/10ps
`include "edp_params.svh"

module edpAlu (
  input  edpPkg::tWord    a,
  input  edpPkg::tWord    b,
  input  edpPkg::tAluFunc func,
  input  logic            carryIn,
  output edpPkg::tWord    ad,
  output logic            carry,
  output logic            overflow
);
  import edpPkg::*;

  // B as the adder sees it, complemented for subtract
  tWord bOp;
  logic cIn;
  logic arith;
  logic [`WORD_W:0] sum;

  always_comb begin
    arith = (func == aluAdd) || (func == aluSub);
    if (func == aluSub) begin
      bOp = ~b;
      cIn = 1'b1;
    end else begin
      bOp = b;
      cIn = carryIn;
    end
    // Extra top bit catches the carry out of bit 0
    sum = {1'b0, a} + {1'b0, bOp} + {{`WORD_W{1'b0}}, cIn};
  end

  always_comb begin
    case (func)
      aluAdd, aluSub: begin
        ad = sum[`WORD_W-1:0];
      end
      aluAnd: begin
        ad = a & b;
      end
      aluOr: begin
        ad = a | b;
      end
      aluXor: begin
        ad = a ^ b;
      end
      aluPassA: begin
        ad = a;
      end
      default: begin
        ad = '0;
      end
    endcase
  end

  // Carry and overflow only mean something for the adder functions
  assign carry = arith & sum[`WORD_W];

  // Same operand signs but a different result sign
  assign overflow = arith & (a[0] == bOp[0]) & (ad[0] != a[0]);

  always_comb begin
    if (!$isunknown(func)) begin
      assert (func inside {aluAdd, aluSub, aluAnd, aluOr, aluXor, aluPassA})
        else $error("edpAlu: undefined function code %0d", func);
    end
  end

endmodule

// File: src/edpPkg.sv
`include "edp_params.svh"

package edpPkg;

  // Bit 0 is the sign bit, as on the real machine
  typedef logic [0:`WORD_W-1] tWord;
  typedef logic [0:`HALF_W-1] tHalf;
  typedef logic [`FM_ADR_W-1:0] tFmAdr;

  typedef enum logic [1:0] {adaAR, adaARX, adaMQ, adaZero} tAdaSel;
  typedef enum logic [1:0] {adbFM, adbBR, adbBRx2, adbARx4} tAdbSel;

  typedef enum logic [2:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor, aluPassA
  } tAluFunc;

  typedef enum logic [1:0] {arCache, arAd, arEbus, arMq} tArSel;
  typedef enum logic [1:0] {mqHold, mqLoad, mqShl, mqShr} tMqFunc;

  // Diagnostic read selector, same order as the hardware DIAG function
  typedef enum logic [`DIAG_W-1:0] {
    diagAR, diagBR, diagMQ, diagFM, diagBRX, diagARX, diagAD, diagZero
  } tDiagSel;

  typedef struct packed {
    tAdaSel  ada;
    tAdbSel  adb;
    tAluFunc aluFunc;
    logic    carryIn;
    tArSel   arSel;
    logic    arLoad;
    logic    arxLoad;
    logic    brLoad;
    logic    brxLoad;
    tMqFunc  mqFunc;
    tFmAdr   fmAdr;
    logic    fmWriteL;
    logic    fmWriteR;
  } tMicroWord;

  // What a peer offers the EBUS arbiter
  typedef struct packed {
    logic req;
    tWord data;
  } tBusReq;

  typedef enum logic [1:0] {ownNone, ownEdp, ownTime} tOwner;

endpackage

// File: src/edp_params.svh
`ifndef EDP_PARAMS_SVH
`define EDP_PARAMS_SVH

// Data word width, one machine word
`define WORD_W 36

// Halfword width for left/right write enables
`define HALF_W (`WORD_W / 2)

// Fast memory depth in words
`define FM_DEPTH 16

// FM address width derived from depth
`define FM_ADR_W $clog2(`FM_DEPTH)

// Diagnostic register selector width
`define DIAG_W 3

`endif
